// File: raster_params.svh
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// ----------------------------------------
// vertex fetch sizing
// ----------------------------------------

// the triangle FIFO holds 2**VF_FIFO_DEPTH_LOG2 records.
`define VF_FIFO_DEPTH_LOG2 2

// three vertices of five words each.
`define VF_WORDS_PER_TRI 15

// byte address width of the memory bus.
`define VF_ADDR_W 26

`endif

// File: bus_pkg.sv
`default_nettype none

`include "raster_params.svh"

package bus_pkg;

    // byte address, word aligned in practice.
    typedef logic [`VF_ADDR_W-1:0] addr_t;

    typedef logic [31:0] word_t; // one bus data word.

    typedef logic [3:0] byte_en_t;

endpackage

`default_nettype wire

// File: raster_pkg.sv
`default_nettype none

`include "raster_params.svh"

package raster_pkg;

    // the header word is taken whole as the count.
    typedef logic [$bits(bus_pkg::word_t)-1:0] tri_count_t;

    typedef logic [3:0] word_idx_t; // word position inside a triangle.

    // word 0 of the triangle sits in the low bits.
    typedef logic [`VF_WORDS_PER_TRI*$bits(bus_pkg::word_t)-1:0] tri_rec_t;

    // ----------------------------------------
    // state machines
    // ----------------------------------------
    typedef enum logic [2:0] {
        REQ_IDLE,
        REQ_HEADER,
        REQ_WAIT_COUNT,
        REQ_TRI,
        REQ_DONE
    } req_state_t;

    typedef enum logic {
        ASM_HEADER,
        ASM_WORDS
    } asm_state_t;

endpackage

`default_nettype wire

// File: vertex_read_requester.sv
`default_nettype none

`include "raster_params.svh"

module vertex_read_requester (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   fetch_enable,
    input  wire logic                   master_waitrequest,
    input  wire logic                   count_valid,
    input  wire logic                   credit_return,
    input  wire bus_pkg::addr_t         vertex_buffer_base,
    input  wire raster_pkg::tri_count_t tri_count,
    output bus_pkg::addr_t              master_address,
    output logic                        master_read,
    output logic                        done_out
);

    localparam logic [`VF_FIFO_DEPTH_LOG2:0] credit_full =
        {1'b1, {`VF_FIFO_DEPTH_LOG2{1'b0}}};
    localparam raster_pkg::word_idx_t last_word =
        raster_pkg::word_idx_t'(`VF_WORDS_PER_TRI - 1);

    raster_pkg::req_state_t state;
    raster_pkg::tri_count_t total;
    raster_pkg::tri_count_t issued;
    raster_pkg::tri_count_t delivered;
    raster_pkg::word_idx_t  word_cnt;
    logic [`VF_FIFO_DEPTH_LOG2:0] credits;
    logic accepted;
    logic start_tri;

    assign accepted = master_read && !master_waitrequest;

    // a triangle starts only from an idle bus and with a free FIFO slot.
    assign start_tri = (state == raster_pkg::REQ_TRI) && !master_read &&
                       (issued < total) && (credits != '0);

    // ----------------------------------------
    // read sequencing
    // ----------------------------------------
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state          <= raster_pkg::REQ_IDLE;
            master_address <= '0;
            master_read    <= 1'b0;
            total          <= '0;
            issued         <= '0;
            word_cnt       <= '0;
            done_out       <= 1'b0;
        end else begin
            case (state)
                raster_pkg::REQ_IDLE: begin
                    if (fetch_enable) begin
                        master_address <= vertex_buffer_base;
                        master_read    <= 1'b1;
                        state          <= raster_pkg::REQ_HEADER;
                    end
                end
                raster_pkg::REQ_HEADER: begin
                    if (accepted) begin
                        master_read    <= 1'b0;
                        master_address <= master_address + bus_pkg::addr_t'(4);
                        state          <= raster_pkg::REQ_WAIT_COUNT;
                    end
                end
                raster_pkg::REQ_WAIT_COUNT: begin
                    if (count_valid) begin
                        total <= tri_count;
                        if (tri_count == '0) begin
                            done_out <= 1'b1; // empty buffer, nothing to deliver.
                            state    <= raster_pkg::REQ_DONE;
                        end else begin
                            state <= raster_pkg::REQ_TRI;
                        end
                    end
                end
                raster_pkg::REQ_TRI: begin
                    if (start_tri) begin
                        master_read <= 1'b1;
                    end else if (accepted) begin
                        master_address <= master_address + bus_pkg::addr_t'(4);
                        if (word_cnt == last_word) begin
                            master_read <= 1'b0; // forces a gap before the next triangle.
                            word_cnt    <= '0;
                            issued      <= issued + 1'b1;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end else if (delivered == total) begin
                        done_out <= 1'b1;
                        state    <= raster_pkg::REQ_DONE;
                    end
                end
                raster_pkg::REQ_DONE: done_out <= 1'b1; // held until the next reset.
                default: state <= raster_pkg::REQ_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // credits and delivery count
    // ----------------------------------------
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            credits   <= credit_full;
            delivered <= '0;
        end else begin
            if (credit_return) delivered <= delivered + 1'b1;
            case ({start_tri, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: vertex_assembler.sv
`default_nettype none

`include "raster_params.svh"

module vertex_assembler (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            master_readdatavalid,
    input  wire bus_pkg::word_t  master_readdata,
    output logic                 count_valid,
    output raster_pkg::tri_count_t tri_count,
    output logic                 push,
    output raster_pkg::tri_rec_t push_rec
);

    localparam int word_w = $bits(bus_pkg::word_t);
    localparam raster_pkg::word_idx_t last_word =
        raster_pkg::word_idx_t'(`VF_WORDS_PER_TRI - 1);

    raster_pkg::asm_state_t state;
    raster_pkg::word_idx_t  word_idx;

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state       <= raster_pkg::ASM_HEADER;
            word_idx    <= '0;
            count_valid <= 1'b0;
            push        <= 1'b0;
        end else begin
            count_valid <= 1'b0;
            push        <= 1'b0;
            if (master_readdatavalid) begin
                if (state == raster_pkg::ASM_HEADER) begin
                    count_valid <= 1'b1;
                    state       <= raster_pkg::ASM_WORDS;
                end else if (word_idx == last_word) begin
                    push     <= 1'b1; // record is complete on the next cycle.
                    word_idx <= '0;
                end else begin
                    word_idx <= word_idx + 1'b1;
                end
            end
        end
    end

    // the next triangle's first word lands one edge after the push,
    // so the FIFO always captures a whole record.
    always_ff @(posedge clock) begin
        if (master_readdatavalid) begin
            if (state == raster_pkg::ASM_HEADER) begin
                tri_count <= master_readdata;
            end else begin
                push_rec[word_idx * word_w +: word_w] <= master_readdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: triangle_fifo.sv
`default_nettype none

`include "raster_params.svh"

module triangle_fifo #(
    parameter int depth_log2 = 2
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 push,
    input  wire raster_pkg::tri_rec_t push_rec,
    input  wire logic                 stall_in,
    output logic                      output_valid,
    output bus_pkg::word_t            vertex_out [`VF_WORDS_PER_TRI-1:0],
    output logic                      credit_return
);

    localparam int word_w = $bits(bus_pkg::word_t);

    raster_pkg::tri_rec_t mem [2**depth_log2];
    raster_pkg::tri_rec_t head;
    logic [depth_log2:0]  wr_ptr; // extra bit tells full from empty.
    logic [depth_log2:0]  rd_ptr;
    logic                 deliver;

    assign output_valid = (wr_ptr != rd_ptr);
    assign deliver      = output_valid && !stall_in;
    assign head         = mem[rd_ptr[depth_log2-1:0]];

    always_comb begin
        for (int i = 0; i < `VF_WORDS_PER_TRI; i++) begin
            vertex_out[i] = head[i * word_w +: word_w];
        end
    end

    // ----------------------------------------
    // pointers and credit return
    // ----------------------------------------
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (deliver) rd_ptr <= rd_ptr + 1'b1;
            credit_return <= deliver; // one slot freed per delivery.
        end
    end

    // no full check here since the requester never holds more
    // triangles in flight than there are slots.
    always_ff @(posedge clock) begin
        if (push) mem[wr_ptr[depth_log2-1:0]] <= push_rec;
    end

endmodule

`default_nettype wire

// File: vertex_fetch_top.sv
`default_nettype none

`include "raster_params.svh"

module vertex_fetch_top (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             fetch_enable,
    input  wire bus_pkg::addr_t   vertex_buffer_base,
    input  wire bus_pkg::word_t   master_readdata,
    input  wire logic             master_readdatavalid,
    input  wire logic             master_waitrequest,
    input  wire logic             stall_in,
    output bus_pkg::addr_t        master_address,
    output logic                  master_read,
    output bus_pkg::byte_en_t     master_byteenable,
    output logic                  output_valid,
    output bus_pkg::word_t        vertex_out [`VF_WORDS_PER_TRI-1:0],
    output logic                  done_out
);

    logic                   count_valid;
    raster_pkg::tri_count_t tri_count;
    logic                   push;
    raster_pkg::tri_rec_t   push_rec;
    logic                   credit_return;

    assign master_byteenable = '1; // reads only, always whole words.

    // ----------------------------------------
    // stage blocks
    // ----------------------------------------
    vertex_read_requester requester0 (
        .clock              (clock),
        .reset              (reset),
        .fetch_enable       (fetch_enable),
        .master_waitrequest (master_waitrequest),
        .count_valid        (count_valid),
        .credit_return      (credit_return),
        .vertex_buffer_base (vertex_buffer_base),
        .tri_count          (tri_count),
        .master_address     (master_address),
        .master_read        (master_read),
        .done_out           (done_out)
    );

    vertex_assembler assembler0 (
        .clock                (clock),
        .reset                (reset),
        .master_readdatavalid (master_readdatavalid),
        .master_readdata      (master_readdata),
        .count_valid          (count_valid),
        .tri_count            (tri_count),
        .push                 (push),
        .push_rec             (push_rec)
    );

    triangle_fifo #(
        .depth_log2 (`VF_FIFO_DEPTH_LOG2)
    ) fifo0 (
        .clock         (clock),
        .reset         (reset),
        .push          (push),
        .push_rec      (push_rec),
        .stall_in      (stall_in),
        .output_valid  (output_valid),
        .vertex_out    (vertex_out),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

// File: vertex_fetch_chk.sv
`default_nettype none

module vertex_fetch_chk (
    input wire logic              clock,
    input wire logic              reset,
    input wire bus_pkg::addr_t    master_address,
    input wire logic              master_read,
    input wire logic              master_waitrequest,
    input wire bus_pkg::byte_en_t master_byteenable,
    input wire logic              output_valid,
    input wire logic              done_out
);

    int failures = 0;

    // ----------------------------------------
    // bus side
    // ----------------------------------------
    property read_held;
        @(posedge clock) disable iff (!reset)
            master_read && master_waitrequest |=> master_read && $stable(master_address);
    endproperty

    property whole_words;
        @(posedge clock) disable iff (!reset) master_byteenable == '1;
    endproperty

    // the stage leaves reset quiet on both sides.
    property quiet_after_reset;
        @(posedge clock) $rose(reset) |-> !master_read && !output_valid && !done_out;
    endproperty

    property done_sticky;
        @(posedge clock) disable iff (!reset) done_out |=> done_out;
    endproperty

    a_read_held: assert property (read_held)
        else begin
            failures++;
            $error("read request changed while waitrequest was high");
        end
    a_whole_words: assert property (whole_words)
        else begin
            failures++;
            $error("byte enable is not all ones");
        end
    a_quiet_after_reset: assert property (quiet_after_reset)
        else begin
            failures++;
            $error("outputs active right after reset");
        end
    a_done_sticky: assert property (done_sticky)
        else begin
            failures++;
            $error("done_out fell before reset");
        end

endmodule

`default_nettype wire

// File: vertex_fetch_tb.sv
`default_nettype none

`include "raster_params.svh"

module vertex_fetch_tb;

    localparam int clk_period = 4;
    localparam int max_tris   = 9;
    localparam int mem_n      = 1 + `VF_WORDS_PER_TRI * max_tris;
    localparam int total_tris = 3 + 9 + 0 + 1; // sum of the counts run below.

    logic              clock;
    logic              reset = 1'b0;
    logic              fetch_enable = 1'b0;
    bus_pkg::addr_t    vertex_buffer_base = '0;
    bus_pkg::word_t    master_readdata = '0;
    logic              master_readdatavalid = 1'b0;
    logic              master_waitrequest = 1'b0;
    logic              stall_in = 1'b0;
    bus_pkg::addr_t    master_address;
    logic              master_read;
    bus_pkg::byte_en_t master_byteenable;
    logic              output_valid;
    bus_pkg::word_t    vertex_out [`VF_WORDS_PER_TRI-1:0];
    logic              done_out;

    bus_pkg::word_t mem_words [0:mem_n-1];
    bus_pkg::word_t read_q [$];
    int             exp_q [$]; // indices of triangles not yet delivered.
    bus_pkg::addr_t cur_base;
    int  cur_count = 0;
    bit  cur_stall = 1'b0;
    int  n_reads = 0;
    int  gap = 0;
    int  idx;
    int  k;
    int  errors = 0;
    int  checks = 0;
    int  tests_run = 0;

    vertex_fetch_top dut0 (.*);

    bind vertex_fetch_top vertex_fetch_chk chk0 (
        .clock              (clock),
        .reset              (reset),
        .master_address     (master_address),
        .master_read        (master_read),
        .master_waitrequest (master_waitrequest),
        .master_byteenable  (master_byteenable),
        .output_valid       (output_valid),
        .done_out           (done_out)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_addr(string name, bus_pkg::addr_t got, bus_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(string name, bus_pkg::word_t got, bus_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ----------------------------------------
    // memory model
    // ----------------------------------------
    always @(posedge clock) begin
        if (!reset) begin
            read_q.delete();
            gap = 0;
            n_reads = 0;
            master_readdatavalid <= 1'b0;
            master_waitrequest   <= 1'b0;
        end else begin
            if (gap > 0) begin
                gap--;
                master_readdatavalid <= 1'b0;
            end else if (read_q.size() > 0) begin
                master_readdata      <= read_q.pop_front();
                master_readdatavalid <= 1'b1;
                gap = $urandom_range(0, 3); // 1 to 4 cycles between returned words.
            end else begin
                master_readdatavalid <= 1'b0;
            end
            if (master_read && !master_waitrequest) begin
                if (n_reads >= 1 + `VF_WORDS_PER_TRI * cur_count) begin
                    errors++;
                    $display("read at %0t issued past the end of the vertex buffer", $time);
                end else begin
                    check_addr("master_address", master_address,
                               cur_base + bus_pkg::addr_t'(4 * n_reads));
                end
                idx = int'((master_address - cur_base) >> 2);
                read_q.push_back((idx >= 0 && idx < mem_n) ? mem_words[idx] : '0);
                n_reads++;
            end
            master_waitrequest <= ($urandom_range(0, 2) == 0);
        end
    end

    always @(posedge clock) stall_in <= cur_stall ? 1'($urandom_range(0, 1)) : 1'b0;

    // delivered records against the buffer layout.
    always @(posedge clock) begin
        if (reset && output_valid && !stall_in) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("triangle delivered at %0t that the buffer does not hold", $time);
            end else begin
                k = exp_q.pop_front();
                for (int j = 0; j < `VF_WORDS_PER_TRI; j++) begin
                    check_word($sformatf("vertex_out[%0d]", j), vertex_out[j],
                               mem_words[1 + `VF_WORDS_PER_TRI * k + j]);
                end
            end
        end
        if (reset && done_out && exp_q.size() != 0) begin
            errors++;
            $display("done_out high at %0t with %0d triangles undelivered", $time, exp_q.size());
        end
    end

    task automatic run_test(string name, int count, bit stall_mode);
        int err_before;
        err_before = errors;
        @(posedge clock);
        reset        <= 1'b0;
        fetch_enable <= 1'b0;
        @(posedge clock); // the stage is held in reset before the model changes.
        cur_count = count;
        cur_stall = stall_mode;
        cur_base  = bus_pkg::addr_t'($urandom_range(0, 'h3ffff)) << 2;
        vertex_buffer_base <= cur_base;
        for (int i = 0; i < mem_n; i++) mem_words[i] = $urandom;
        mem_words[0] = count; // header word.
        exp_q.delete();
        for (int t = 0; t < count; t++) exp_q.push_back(t);
        repeat (9) @(posedge clock);
        check_flag("master_read", master_read, 1'b0);
        check_flag("output_valid", output_valid, 1'b0);
        check_flag("done_out", done_out, 1'b0);
        reset <= 1'b1;
        @(posedge clock);
        fetch_enable <= 1'b1;
        while (!done_out) @(posedge clock);
        repeat (30) @(posedge clock); // stray reads or deliveries would show here.
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d triangles were never delivered", exp_q.size());
        end
        if (n_reads != 1 + `VF_WORDS_PER_TRI * count) begin
            errors++;
            $display("%0d reads accepted where %0d were due", n_reads,
                     1 + `VF_WORDS_PER_TRI * count);
        end
        check_flag("done_out", done_out, 1'b1);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    initial begin
        void'($urandom(32'ha7d66028));
        run_test("basic", 3, 1'b0);
        run_test("stalled", 9, 1'b1);
        run_test("zero count", 0, 1'b0);
        run_test("single stalled", 1, 1'b1);
        $display("tests run %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, checks, errors, dut0.chk0.failures);
        if (errors == 0 && dut0.chk0.failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #((200 * total_tris + 1000) * clk_period);
        $display("watchdog expired before all tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
bus_pkg.sv
raster_pkg.sv
vertex_read_requester.sv
vertex_assembler.sv
triangle_fifo.sv
vertex_fetch_top.sv
vertex_fetch_chk.sv
vertex_fetch_tb.sv
